// File: rtl/preparse_pkg.sv
// shared sizes, tag codes and controller states of the snappy slice parser
package preparse_pkg;

	localparam int BEAT_BYTES  = 16;                        // bytes per input beat
	localparam int LOOK_BYTES  = 2;                         // bytes borrowed from next beat
	localparam int SLICE_BYTES = BEAT_BYTES + LOOK_BYTES;   // 18 byte slice

	typedef logic [BEAT_BYTES*8-1:0]  beat_t;
	typedef logic [SLICE_BYTES*8-1:0] slice_t;   // current beat in the high bytes
	typedef logic [BEAT_BYTES-1:0]    mask_t;    // msb is byte 0
	typedef logic [8:0]               tag_len_t; // up to 256 literal bytes
	typedef logic [15:0]              lit_len_t;

	localparam logic [7:0] LIT1_CODE = 8'hF0;    // literal, length in next byte

	// low two bits of a tag byte
	localparam logic [1:0] TAG_LIT   = 2'b00;
	localparam logic [1:0] TAG_COPY1 = 2'b01;
	localparam logic [1:0] TAG_COPY2 = 2'b10;

	typedef enum logic [1:0] {
		st_idle,
		st_run,
		st_flush,
		st_done
	} ctrl_state_t;

	// header size of a tag in bytes, literal content not counted
	function automatic logic [1:0] hdr_bytes(input logic [7:0] b);
		case (b[1:0])
			TAG_LIT:   return (b == LIT1_CODE) ? 2'd2 : 2'd1;
			TAG_COPY1: return 2'd2;
			TAG_COPY2: return 2'd3;
			default:   return 2'd1; // 4-byte offset copy never produced here
		endcase
	endfunction

endpackage

// File: rtl/slice_if.sv
// one 18-byte slice with its tail mask, valid and last flags
`timescale 1ns/10ps

interface slice_if ();
	import preparse_pkg::*;

	slice_t slice;  // beat plus two lookahead bytes
	mask_t  mask;   // tail mask, all ones except on the last slice
	logic   valid;  // slice counts only while high
	logic   last;   // last slice of a stream

	modport src (
		output slice, mask, valid, last
	);

	modport dst (
		input slice, mask, valid, last
	);

endinterface

// File: rtl/stream_ctrl.sv
// stream sequencer, steps through idle, run, flush and done and drives finish
`timescale 1ns/10ps

module stream_ctrl (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	input  logic valid,
	input  logic last_beat,
	output logic running,
	output logic flush,
	output logic finish
);
	import preparse_pkg::*;

	ctrl_state_t state;
	ctrl_state_t state_nxt;

	//////////////////////////////////////////////////
	// next state
	always_comb begin
		state_nxt = state;
		case (state)
			st_idle:  if (start) state_nxt = st_run;
			st_run:   if (valid && last_beat) state_nxt = st_flush; // last beat seen
			st_flush: state_nxt = st_done;      // single cycle, emits held beat
			st_done:  if (start) state_nxt = st_run; // next stream starts straight away
			default:  state_nxt = st_idle;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= st_idle;
		end else begin
			state <= state_nxt;
		end
	end

	//////////////////////////////////////////////////
	// decoded outputs
	assign running = (state == st_run);   // beats accepted
	assign flush   = (state == st_flush); // one cycle after the last beat
	assign finish  = (state == st_done);  // held until next start

endmodule

// File: rtl/beat_counter.sv
// counts beats against the compressed length, flags the last one and builds the tail mask
`timescale 1ns/10ps

module beat_counter #(
	parameter int LEN_W = 35
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                start,
	input  logic                valid,
	input  logic [LEN_W-1:0]    compression_length,
	output logic                last_beat,
	output preparse_pkg::mask_t tail_mask
);
	import preparse_pkg::*;

	localparam int LOG_B = $clog2(BEAT_BYTES); // byte index bits within a beat
	localparam int CNT_W = LEN_W - LOG_B;

	logic [CNT_W-1:0] cnt_q;    // beats taken so far
	logic [CNT_W-1:0] total_q;  // length rounded up to whole beats
	logic             armed_q;  // between start and last beat
	logic [LOG_B-1:0] rem;

	assign rem = compression_length[LOG_B-1:0];

	// pulse on the beat that completes the stream
	assign last_beat = armed_q & valid & (cnt_q + 1'b1 == total_q);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			armed_q   <= 1'b0;
			cnt_q     <= '0;
			total_q   <= '0;
			tail_mask <= '1;
		end else if (start) begin
			armed_q   <= 1'b1;
			cnt_q     <= '0;
			total_q   <= compression_length[LEN_W-1:LOG_B] + CNT_W'(|rem); // partial beat
			tail_mask <= (rem == '0) ? '1 : ~(mask_t'('1) >> rem); // keep first rem bytes
		end else if (armed_q && valid) begin
			cnt_q <= cnt_q + 1'b1;
			if (last_beat)
				armed_q <= 1'b0; // ignore stray beats after the end
		end
	end

endmodule

// File: rtl/slice_builder.sv
// joins each held beat with the next beat's first two bytes and flushes the last one
`timescale 1ns/10ps

module slice_builder (
	input  logic                clk,
	input  logic                rst_n,
	input  preparse_pkg::beat_t data,
	input  logic                valid,
	input  logic                running,
	input  logic                flush,
	input  preparse_pkg::mask_t tail_mask,
	slice_if.src                out
);
	import preparse_pkg::*;

	beat_t held_q;     // previous beat, waits for its lookahead
	logic  have_q;     // held_q carries a beat of this stream
	logic  take;

	assign take = valid & running;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			have_q    <= 1'b0;
			out.valid <= 1'b0;
			out.last  <= 1'b0;
		end else begin
			// first beat of a stream only fills held_q
			out.valid <= (take | flush) & have_q;
			out.last  <= flush & have_q;
			if (flush)
				have_q <= 1'b0;
			else if (take)
				have_q <= 1'b1;
		end

		if (take)
			held_q <= data;

		if (flush) begin
			out.slice <= {held_q, {LOOK_BYTES*8{1'b0}}}; // no lookahead after the end
			out.mask  <= tail_mask;
		end else begin
			out.slice <= {held_q, data[BEAT_BYTES*8-1 -: LOOK_BYTES*8]};
			out.mask  <= '1;
		end
	end

endmodule

// File: rtl/tag_decoder.sv
// per-byte candidate tag decode, every byte taken as a possible tag start
`timescale 1ns/10ps

module tag_decoder (
	input  logic                   clk,
	input  logic                   rst_n,
	slice_if.dst                   in,
	slice_if.src                   out,
	output preparse_pkg::mask_t    cand_pos [preparse_pkg::BEAT_BYTES],
	output preparse_pkg::tag_len_t cand_len [preparse_pkg::BEAT_BYTES],
	output preparse_pkg::lit_len_t cand_lit [preparse_pkg::BEAT_BYTES]
);
	import preparse_pkg::*;

	localparam int TOP = SLICE_BYTES*8 - 1; // msb of byte 0

	mask_t    pos_c [BEAT_BYTES];
	tag_len_t len_c [BEAT_BYTES];
	lit_len_t lit_c [BEAT_BYTES];

	//////////////////////////////////////////////////
	// one decoder per byte position
	for (genvar i = 0; i < BEAT_BYTES; i++) begin : g_byte
		logic [7:0] b0;       // tag byte
		logic [7:0] b1;       // length byte of the 0xF0 form
		logic [1:0] hdr;
		tag_len_t   room;     // literal bytes that still fit in the beat
		tag_len_t   lit_len;
		tag_len_t   len;
		logic [9:0] nxt;      // position of the following tag, may pass 15

		assign b0   = in.slice[TOP-8*i -: 8];
		assign b1   = in.slice[TOP-8*(i+1) -: 8]; // byte 16 is lookahead for i=15
		assign hdr  = hdr_bytes(b0);
		assign room = (i + hdr < BEAT_BYTES) ? tag_len_t'(BEAT_BYTES - i - hdr) : '0;

		always_comb begin
			lit_len = (b0 == LIT1_CODE) ? tag_len_t'(b1) + 9'd1 : tag_len_t'(b0[7:2]) + 9'd1;
			if (b0[1:0] == TAG_COPY1) begin
				len = tag_len_t'(b0[4:2]) + 9'd4;     // 4..11 bytes
				nxt = 10'(i) + hdr;
			end else if (b0[1:0] == TAG_COPY2) begin
				len = tag_len_t'(b0[7:2]) + 9'd1;     // 1..64 bytes
				nxt = 10'(i) + hdr;
			end else begin
				len = (lit_len < room) ? lit_len : room; // part inside the beat
				nxt = 10'(i) + hdr + lit_len;
			end
		end

		assign len_c[i] = len;
		assign lit_c[i] = (nxt > 10'(i) + hdr) ? lit_len_t'(lit_len - len) : '0; // literal spill
		assign pos_c[i] = mask_t'('1) >> nxt;     // ones from the next tag onwards
	end

	//////////////////////////////////////////////////
	// stage register
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			out.valid <= 1'b0;
			out.last  <= 1'b0;
		end else begin
			out.valid <= in.valid;
			out.last  <= in.last;
		end
		out.slice <= in.slice;
		out.mask  <= in.mask;
		cand_pos  <= pos_c;
		cand_len  <= len_c;
		cand_lit  <= lit_c;
	end

endmodule

// File: rtl/token_chain.sv
// resolves real tag starts from the candidates and carries literal state across slices
`timescale 1ns/10ps

module token_chain (
	input  logic                   clk,
	input  logic                   rst_n,
	slice_if.dst                   in,
	input  preparse_pkg::mask_t    cand_pos [preparse_pkg::BEAT_BYTES],
	input  preparse_pkg::lit_len_t cand_lit [preparse_pkg::BEAT_BYTES],
	slice_if.src                   out,
	output preparse_pkg::mask_t    real_pos,
	output preparse_pkg::lit_len_t lit_in,
	output logic                   start_lit
);
	import preparse_pkg::*;

	localparam int TOP = SLICE_BYTES*8 - 1;

	lit_len_t    lit_q;    // literal content still owed at slice entry
	logic [1:0]  head_q;   // header bytes of a tag from the previous slice
	logic [16:0] skip;
	mask_t       entry;    // bytes not covered by carried state
	mask_t       real_b;   // unmasked real starts, msb is byte 0
	logic        ok;
	lit_len_t    spill;
	lit_len_t    lit_c;    // carried content inside this slice
	lit_len_t    lit_nxt;
	logic [1:0]  head_nxt;
	logic [4:0]  space;    // beat bytes left after carried header
	logic [1:0]  hdr14;
	logic [1:0]  hdr15;

	assign hdr14 = hdr_bytes(in.slice[TOP-8*14 -: 8]);
	assign hdr15 = hdr_bytes(in.slice[TOP-8*15 -: 8]);
	assign space = 5'(BEAT_BYTES) - head_q;

	//////////////////////////////////////////////////
	// prefix chain
	always_comb begin
		skip  = {1'b0, lit_q} + head_q;
		entry = mask_t'('1) >> skip;
		for (int j = 0; j < BEAT_BYTES; j++) begin
			ok = entry[BEAT_BYTES-1-j];
			for (int i = 0; i < j; i++)
				ok = ok & (~real_b[BEAT_BYTES-1-i] | cand_pos[i][BEAT_BYTES-1-j]); // covered by i
			real_b[BEAT_BYTES-1-j] = ok;
		end

		// only the last real tag can reach past the beat
		spill = '0;
		for (int j = 0; j < BEAT_BYTES; j++)
			spill = spill | (real_b[BEAT_BYTES-1-j] ? cand_lit[j] : '0);
	end

	//////////////////////////////////////////////////
	// carry update
	always_comb begin
		if (lit_q >= lit_len_t'(space)) begin
			lit_c    = lit_len_t'(space);  // whole beat is literal content
			lit_nxt  = lit_q - lit_len_t'(space);
			head_nxt = 2'd0;
		end else begin
			lit_c   = lit_q;
			lit_nxt = spill;
			if (real_b[0])
				head_nxt = hdr15 - 2'd1;       // byte 15 header runs into lookahead
			else if (real_b[1] && hdr14 == 2'd3)
				head_nxt = 2'd1;               // 2-byte offset copy at byte 14
			else
				head_nxt = 2'd0;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			lit_q     <= '0;
			head_q    <= 2'd0;
			out.valid <= 1'b0;
			out.last  <= 1'b0;
		end else begin
			out.valid <= in.valid;
			out.last  <= in.last;
			if (in.valid) begin
				lit_q  <= in.last ? '0 : lit_nxt;  // next stream starts on a tag
				head_q <= in.last ? 2'd0 : head_nxt;
			end
		end
		out.slice <= in.slice;
		out.mask  <= in.mask;
		real_pos  <= real_b & in.mask;   // drop bytes past the length
		lit_in    <= lit_c;
		start_lit <= (lit_q != '0);
	end

endmodule

// File: rtl/length_accum.sv
// sums decompressed lengths of real tags into the slice start address
`timescale 1ns/10ps

module length_accum #(
	parameter int ADDR_W = 17
) (
	input  logic                   clk,
	input  logic                   rst_n,
	slice_if.dst                   in,
	input  preparse_pkg::mask_t    real_pos,
	input  preparse_pkg::tag_len_t cand_len [preparse_pkg::BEAT_BYTES],
	input  preparse_pkg::lit_len_t lit_in,
	input  logic                   start_lit,
	output preparse_pkg::slice_t   data_out,
	output preparse_pkg::mask_t    token_pos,
	output logic [ADDR_W-1:0]      address,
	output logic                   start_lit_out,
	output logic                   valid_out
);
	import preparse_pkg::*;

	tag_len_t    len_q [BEAT_BYTES];   // lengths lined up with real_pos
	logic [9:0]  lvl1 [8];
	logic [10:0] lvl2 [4];
	logic [11:0] lvl3 [2];
	logic [12:0] slice_len;
	logic [4:0]  lit_cap;
	logic [ADDR_W-1:0] sum_q;    // bytes before the next slice
	logic        first_q;        // next slice opens a stream

	//////////////////////////////////////////////////
	// adder tree over the 16 byte positions
	always_comb begin
		for (int n = 0; n < 8; n++)
			lvl1[n] = 10'(real_pos[15-2*n] ? len_q[2*n] : '0)
				+ 10'(real_pos[14-2*n] ? len_q[2*n+1] : '0);
		for (int n = 0; n < 4; n++)
			lvl2[n] = 11'(lvl1[2*n]) + 11'(lvl1[2*n+1]);
		for (int n = 0; n < 2; n++)
			lvl3[n] = 12'(lvl2[2*n]) + 12'(lvl2[2*n+1]);
		lit_cap   = (lit_in > 16'd16) ? 5'd16 : lit_in[4:0];
		slice_len = 13'(lvl3[0]) + 13'(lvl3[1]) + 13'(lit_cap);
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			sum_q     <= '0;
			first_q   <= 1'b1;
			valid_out <= 1'b0;
		end else begin
			valid_out <= in.valid & ((|real_pos) | start_lit); // empty slices dropped
			if (in.valid) begin
				first_q <= in.last;
				sum_q   <= (first_q ? '0 : sum_q) + ADDR_W'(slice_len); // wraps
			end
		end
		len_q         <= cand_len;
		address       <= first_q ? '0 : sum_q;
		data_out      <= in.slice;
		token_pos     <= real_pos;
		start_lit_out <= start_lit;
	end

endmodule

// File: rtl/preparser_top.sv
// first-level snappy parser, turns 16-byte beats into tagged 18-byte slices
`timescale 1ns/10ps

module preparser_top #(
	parameter int LEN_W  = 35,
	parameter int ADDR_W = 17
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  preparse_pkg::beat_t  data,
	input  logic                 valid,
	input  logic                 start,
	input  logic [LEN_W-1:0]     compression_length,
	output preparse_pkg::slice_t data_out,
	output preparse_pkg::mask_t  token_pos,
	output logic [ADDR_W-1:0]    address,
	output logic                 start_lit,
	output logic                 valid_out,
	output logic                 finish
);
	import preparse_pkg::*;

	logic     last_beat;
	logic     running;
	logic     flush;
	mask_t    tail_mask;
	mask_t    cand_pos [BEAT_BYTES];
	tag_len_t cand_len [BEAT_BYTES];
	lit_len_t cand_lit [BEAT_BYTES];
	mask_t    real_pos;
	lit_len_t lit_in;
	logic     chain_lit;

	slice_if sl_raw ();   // builder to decoder
	slice_if sl_dec ();   // decoder to chain
	slice_if sl_chn ();   // chain to accumulator

	//////////////////////////////////////////////////
	// stream control
	stream_ctrl u_ctrl (
		.clk(clk), .rst_n(rst_n), .start(start), .valid(valid), .last_beat(last_beat),
		.running(running), .flush(flush), .finish(finish)
	);

	beat_counter #(.LEN_W(LEN_W)) u_cnt (
		.clk(clk), .rst_n(rst_n), .start(start), .valid(valid),
		.compression_length(compression_length), .last_beat(last_beat), .tail_mask(tail_mask)
	);

	//////////////////////////////////////////////////
	// slice pipeline
	slice_builder u_build (
		.clk(clk), .rst_n(rst_n), .data(data), .valid(valid), .running(running),
		.flush(flush), .tail_mask(tail_mask), .out(sl_raw.src)
	);

	tag_decoder u_dec (
		.clk(clk), .rst_n(rst_n), .in(sl_raw.dst), .out(sl_dec.src),
		.cand_pos(cand_pos), .cand_len(cand_len), .cand_lit(cand_lit)
	);

	token_chain u_chain (
		.clk(clk), .rst_n(rst_n), .in(sl_dec.dst), .cand_pos(cand_pos), .cand_lit(cand_lit),
		.out(sl_chn.src), .real_pos(real_pos), .lit_in(lit_in), .start_lit(chain_lit)
	);

	length_accum #(.ADDR_W(ADDR_W)) u_accum (
		.clk(clk), .rst_n(rst_n), .in(sl_chn.dst), .real_pos(real_pos), .cand_len(cand_len),
		.lit_in(lit_in), .start_lit(chain_lit), .data_out(data_out), .token_pos(token_pos),
		.address(address), .start_lit_out(start_lit), .valid_out(valid_out)
	);

endmodule

// File: test/preparser_checker.sv
// output checker of the slice parser, compares emitted slices in order with expected ones
`timescale 1ns/10ps

module preparser_checker (
	input  logic                 clk,
	input  preparse_pkg::slice_t data_out,
	input  preparse_pkg::mask_t  token_pos,
	input  logic [16:0]          address,
	input  logic                 start_lit,
	input  logic                 valid_out,
	input  logic                 finish
);
	import preparse_pkg::*;

	slice_t      exp_data [$];
	mask_t       exp_tok [$];
	logic [16:0] exp_addr [$];
	logic        exp_lit [$];
	string       test_name = "";
	int          seen = 0;          // slices seen in this test
	int          test_errs = 0;
	int          err_total = 0;
	int          n_pass = 0;
	int          n_fail = 0;

	task automatic open_test(input string name);
		test_name = name;
		seen      = 0;
		test_errs = 0;
	endtask

	task automatic expect_slice(input slice_t d, input mask_t t, input logic [16:0] a,
		input logic s);
		exp_data.push_back(d);
		exp_tok.push_back(t);
		exp_addr.push_back(a);
		exp_lit.push_back(s);
	endtask

	task automatic report_field(input string field, input logic [143:0] got,
		input logic [143:0] want);
		$display("ERROR %0t: test %s slice %0d %s got %0h expected %0h",
			$time, test_name, seen, field, got, want);
		test_errs++;
	endtask

	// finish level against the point the stream has reached
	task automatic check_finish(input logic want);
		if (finish !== want) begin
			$display("ERROR %0t: test %s finish got %b expected %b",
				$time, test_name, finish, want);
			test_errs++;
		end
	endtask

	// close the running test, anything still queued never came out
	task automatic close_test();
		if (exp_data.size() != 0) begin
			$display("test %s: %0d expected slices never came out", test_name, exp_data.size());
			test_errs += exp_data.size();
			exp_data.delete();
			exp_tok.delete();
			exp_addr.delete();
			exp_lit.delete();
		end
		err_total += test_errs;
		if (test_errs == 0) begin
			n_pass++;
			$display("test %s: ok, %0d slices", test_name, seen);
		end else begin
			n_fail++;
			$display("test %s: FAILED with %0d errors", test_name, test_errs);
		end
	endtask

	//////////////////////////////////////////////////
	// sample registered outputs on the edge
	always @(posedge clk) begin
		if (valid_out) begin
			if (exp_data.size() == 0) begin
				$display("test %s: extra slice came out at %0t", test_name, $time);
				test_errs++;
			end else begin
				if (data_out !== exp_data[0]) report_field("data_out", data_out, exp_data[0]);
				if (token_pos !== exp_tok[0]) report_field("token_pos", token_pos, exp_tok[0]);
				if (address !== exp_addr[0]) report_field("address", address, exp_addr[0]);
				if (start_lit !== exp_lit[0]) report_field("start_lit", start_lit, exp_lit[0]);
				void'(exp_data.pop_front());
				void'(exp_tok.pop_front());
				void'(exp_addr.pop_front());
				void'(exp_lit.pop_front());
			end
			seen++;
		end
	end

endmodule

// File: test/preparser_tb.sv
// testbench of the slice parser, streams vector file beats into the DUT and prints a summary
`timescale 1ns/10ps

module preparser_tb;
	import preparse_pkg::*;

	localparam int RST_CYCLES = 16;
	localparam int MAX_T = 32;
	localparam int MAX_B = 256;

	logic        clk;
	logic        rst_n;
	beat_t       data;
	logic        valid;
	logic        start;
	logic [34:0] compression_length;
	slice_t      data_out;
	mask_t       token_pos;
	logic [16:0] address;
	logic        start_lit;
	logic        valid_out;
	logic        finish;

	// vectors as read from the file
	string       t_name [MAX_T];
	logic [34:0] t_len [MAX_T];
	int          t_gaps [MAX_T];
	int          t_first [MAX_T];   // index of first beat
	int          t_nbeat [MAX_T];
	beat_t       beats [MAX_B];
	slice_t      e_data [MAX_B];
	mask_t       e_tok [MAX_B];
	logic [16:0] e_addr [MAX_B];
	logic        e_lit [MAX_B];
	int          e_test [MAX_B];
	int          n_tests = 0;
	int          n_beats = 0;
	int          n_exp = 0;
	int          cycles = 0;
	int          limit = 0;         // 0 until the file is read

	preparser_top #(.LEN_W(35), .ADDR_W(17)) dut (
		.clk(clk), .rst_n(rst_n), .data(data), .valid(valid), .start(start),
		.compression_length(compression_length), .data_out(data_out), .token_pos(token_pos),
		.address(address), .start_lit(start_lit), .valid_out(valid_out), .finish(finish)
	);

	preparser_checker chk (
		.clk(clk), .data_out(data_out), .token_pos(token_pos), .address(address),
		.start_lit(start_lit), .valid_out(valid_out), .finish(finish)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	//////////////////////////////////////////////////
	// run limit
	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles > limit) begin
			$display("timeout: DUT did not finish within %0d cycles", limit);
			$display("Some tests failed");
			$finish;
		end
	end

	task automatic read_vectors();
		int    fd;
		int    n;
		string line;
		fd = $fopen("test/preparser_vectors.txt", "r");
		if (fd == 0) begin
			$display("could not open the vector file test/preparser_vectors.txt");
		end else begin
			limit = RST_CYCLES;
			while (!$feof(fd)) begin
				line = "";
				n = $fgets(line, fd);
				if (line.len() > 1 && line[0] == "T") begin
					n = $sscanf(line, "T %s %h %d", t_name[n_tests], t_len[n_tests],
						t_gaps[n_tests]);
					t_first[n_tests] = n_beats;
					t_nbeat[n_tests] = 0;
					n_tests++;
					limit += 20;
				end else if (line.len() > 1 && line[0] == "B") begin
					n = $sscanf(line, "B %h", beats[n_beats]);
					n_beats++;
					t_nbeat[n_tests-1]++;
					limit += 4;      // beat plus up to 3 idle cycles
				end else if (line.len() > 1 && line[0] == "E") begin
					n = $sscanf(line, "E %h %h %h %h", e_data[n_exp], e_tok[n_exp],
						e_addr[n_exp], e_lit[n_exp]);
					e_test[n_exp] = n_tests - 1;
					n_exp++;
				end
			end
			$fclose(fd);
		end
	endtask

	// one stream, start pulse then beats, then wait for finish and the pipeline tail
	task automatic run_test(input int t);
		int g;
		chk.open_test(t_name[t]);
		for (int e = 0; e < n_exp; e++)
			if (e_test[e] == t)
				chk.expect_slice(e_data[e], e_tok[e], e_addr[e], e_lit[e]);
		start = 1'b1;
		compression_length = t_len[t];
		@(posedge clk);
		#5;
		start = 1'b0;
		chk.check_finish(1'b0);    // start leaves the done state
		for (int k = 0; k < t_nbeat[t]; k++) begin
			data  = beats[t_first[t] + k];
			valid = 1'b1;
			@(posedge clk);
			#5;
			valid = 1'b0;
			if (t_gaps[t] != 0 && k < t_nbeat[t] - 1) begin
				g = $urandom_range(3, 0); // idle gap between beats
				repeat (g) begin
					@(posedge clk);
					#5;
				end
			end
		end
		chk.check_finish(1'b0);    // flush cycle right after the last beat
		@(posedge clk);
		#5;
		chk.check_finish(1'b1);    // finish one cycle after flush
		while (!finish) begin
			@(posedge clk);
			#5;
		end
		repeat (6) @(posedge clk);   // last slice is 3 cycles behind finish
		#5;
		chk.check_finish(1'b1);    // held until the next start
		chk.close_test();
	endtask

	initial begin
		rst_n = 1'b0;
		data  = '0;
		valid = 1'b0;
		start = 1'b0;
		compression_length = '0;
		void'($urandom(94));
		read_vectors();
		repeat (RST_CYCLES) @(posedge clk);
		#5;
		rst_n = 1'b1;
		@(posedge clk);
		#5;
		for (int t = 0; t < n_tests; t++)
			run_test(t);
		$display("summary: %0d tests, %0d passed, %0d failed, %0d errors",
			n_tests, chk.n_pass, chk.n_fail, chk.err_total);
		if (chk.n_fail == 0 && chk.err_total == 0 && n_tests > 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: vlog.f
rtl/preparse_pkg.sv
rtl/slice_if.sv
rtl/stream_ctrl.sv
rtl/beat_counter.sv
rtl/slice_builder.sv
rtl/tag_decoder.sv
rtl/token_chain.sv
rtl/length_accum.sv
rtl/preparser_top.sv
test/preparser_checker.sv
test/preparser_tb.sv

// File: test/preparser_vectors.txt
# T name compressed_length(hex) random_gaps | B beat(byte 0 first)
# E slice(beat + 2 lookahead bytes) token_pos address start_lit
T copy_only 20 0
B 01100110011001100110011001100110
B 05200520052005200520052005200520
E 011001100110011001100110011001100520 aaaa 00000 0
E 052005200520052005200520052005200000 aaaa 00020 0
T edge_cross 30 0
B 2C01010101010101010101010109330E
B 40002802020202020202020202021207
B 000611110D220D220D220D220D220D22
E 2C01010101010101010101010109330E4000 8005 00000 0
E 400028020202020202020202020212070006 2002 00016 0
E 000611110D220D220D220D220D220D220000 4aaa 00026 0
T long_literal 30 0
B F0276161616161616161616161616161
B 61616161616161616161616161616161
B 61616161616161616161052001100933
E F02761616161616161616161616161616161 8000 00000 0
E 616161616161616161616161616161616161 0000 0000e 1
E 616161616161616161610520011009330000 002a 0001e 1
T short_tail 15 0
B 01100110011001100110011001100110
B 061111007A0101010101010101010101
E 011001100110011001100110011001100611 aaaa 00000 0
E 061111007A01010101010101010101010000 9000 00020 0
T b2b_first 20 1
B 0D220D220D220D220D220D220D220D22
B 01100110011001100110011001100110
E 0D220D220D220D220D220D220D220D220110 aaaa 00000 0
E 011001100110011001100110011001100000 aaaa 00038 0
T b2b_second 10 1
B 05200520052005200520052005200520
E 052005200520052005200520052005200000 aaaa 00000 0
